/* tb.f */
+incdir+include
rtl/ctrl_pkg.sv
rtl/alu_pkg.sv
rtl/microcode_store.sv
rtl/control_logic.sv
rtl/mlu.sv
rtl/shifter.sv
rtl/register_bus.sv
rtl/cpu_core.sv
verif/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_cpu_core.sv */
`include "cpu_params.svh"

`default_nettype none

module tb_cpu_core;

  timeunit 1ns;
  timeprecision 100ps;

  import ctrl_pkg::*;
  import alu_pkg::*;

  localparam int CLK_PERIOD = 10;

  // Number of ops over all tests
  // A spaced op takes two cycles
  localparam int NUM_OPS = 7 + 3 * 4 * 2 + 2 * 16 * 3 + 4 * 4 + 9;
  localparam int BOOT_CYCLES = 4 * 64 + 2;
  localparam int WATCHDOG_NS = (2 * NUM_OPS + BOOT_CYCLES + 100) * CLK_PERIOD;

  // Opcode map of the test microcode
  localparam logic [`OPCODE_W-1:0] OPC_ADD_TMP0  = 6'h08;
  localparam logic [`OPCODE_W-1:0] OPC_SHL_TMP1  = 6'h09;
  localparam logic [`OPCODE_W-1:0] OPC_TMP0_REG2 = 6'h0A;
  localparam logic [`OPCODE_W-1:0] OPC_RD_REG2   = 6'h26;
  localparam logic [`OPCODE_W-1:0] OPC_EXT_TMP0  = 6'h28;
  localparam logic [`OPCODE_W-1:0] OPC_EXT_TMP1  = 6'h29;
  localparam logic [`OPCODE_W-1:0] OPC_RD_TMP0   = 6'h2A;
  localparam logic [`OPCODE_W-1:0] OPC_RD_TMP1   = 6'h2B;
  localparam logic [`OPCODE_W-1:0] OPC_SHL       = 6'h2C;
  localparam logic [`OPCODE_W-1:0] OPC_SHR       = 6'h2D;
  localparam logic [`OPCODE_W-1:0] OPC_SAR       = 6'h2E;
  localparam logic [`OPCODE_W-1:0] OPC_NOP       = 6'h2F;
  localparam int                   OPC_MLU_BASE  = 48;

  logic                    clk;
  logic                    arst_n;
  logic                    op_valid;
  logic [`OPCODE_W-1:0]    opcode;
  logic                    booted;
  logic                    boot_we;
  logic [`BOOT_ADDR_W-1:0] boot_addr;
  logic [`DATA_W-1:0]      boot_data;
  logic [`DATA_W-1:0]      ext_data;
  logic                    done;
  logic [`DATA_W-1:0]      bus;
  logic                    carry;

  // Microcode image and reference state
  ctrl_word_t           ucode [64];
  logic [`DATA_W-1:0]   m_regs [`REG_COUNT];
  logic [`DATA_W-1:0]   m_tmp0;
  logic [`DATA_W-1:0]   m_tmp1;
  logic                 m_carry;

  // Op in lookup that executes in the next cycle
  logic                 pend_valid;
  logic [`OPCODE_W-1:0] pend_op;
  logic [`DATA_W-1:0]   pend_ext;
  logic [31:0]          lfsr_state;

  cpu_core u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_valid  (op_valid),
    .opcode    (opcode),
    .booted    (booted),
    .boot_we   (boot_we),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .ext_data  (ext_data),
    .done      (done),
    .bus       (bus),
    .carry     (carry)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed on %s", name);
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [7:0] rand_byte();
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      v = {v[6:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  function automatic ctrl_word_t make_word(input in_plane_e dst, input out_plane_e src,
                                           input logic [3:0] alu, input reg_sel_e sel,
                                           input logic [4:0] src_reg);
    ctrl_word_t w;
    w.in_plane  = dst;
    w.out_plane = src;
    w.alu_plane = alu;
    w.reg_sel   = sel;
    w.reg_src   = src_reg;
    w.unused    = '0;
    return w;
  endfunction

  task automatic build_table();
    for (int i = 0; i < 64; i++) begin
      ucode[6'(i)] = make_word(IN_NONE, OUT_NONE, 4'h0, OP_REG0, 5'd0);
    end
    // Loads and reads for each register select mode
    for (int r = 0; r < 4; r++) begin
      ucode[6'(r)]         = make_word(IN_REG, OUT_EXT, 4'h0, OP_REG0, 5'd0);
      ucode[6'(4 + r)]     = make_word(IN_NONE, OUT_REG, 4'h0, OP_REG0, 5'd0);
      ucode[6'(16 + 4 * r)] = make_word(IN_REG, OUT_EXT, 4'h0, OP_REG1, 5'd0);
      ucode[6'(17 + 4 * r)] = make_word(IN_NONE, OUT_REG, 4'h0, OP_REG1, 5'd0);
      // Upper reg_src bits are set and only the low two count
      ucode[6'(32 + r)]    = make_word(IN_REG, OUT_EXT, 4'h0, CTRL_SRC, {3'b101, 2'(r)});
      ucode[6'(36 + r)]    = make_word(IN_NONE, OUT_REG, 4'h0, CTRL_SRC, {3'b010, 2'(r)});
    end
    ucode[OPC_ADD_TMP0]  = make_word(IN_TMP0, OUT_MLU, 4'b0011, OP_REG0, 5'd0);
    ucode[OPC_SHL_TMP1]  = make_word(IN_TMP1, OUT_SHIFTER, 4'b0000, OP_REG0, 5'd0);
    ucode[OPC_TMP0_REG2] = make_word(IN_REG, OUT_TMP0, 4'h0, CTRL_SRC, 5'd2);
    ucode[OPC_EXT_TMP0]  = make_word(IN_TMP0, OUT_EXT, 4'h0, OP_REG0, 5'd0);
    ucode[OPC_EXT_TMP1]  = make_word(IN_TMP1, OUT_EXT, 4'h0, OP_REG0, 5'd0);
    ucode[OPC_RD_TMP0]   = make_word(IN_NONE, OUT_TMP0, 4'h0, OP_REG0, 5'd0);
    ucode[OPC_RD_TMP1]   = make_word(IN_NONE, OUT_TMP1, 4'h0, OP_REG0, 5'd0);
    ucode[OPC_SHL]       = make_word(IN_NONE, OUT_SHIFTER, 4'b0000, OP_REG0, 5'd0);
    ucode[OPC_SHR]       = make_word(IN_NONE, OUT_SHIFTER, 4'b0001, OP_REG0, 5'd0);
    ucode[OPC_SAR]       = make_word(IN_NONE, OUT_SHIFTER, 4'b0011, OP_REG0, 5'd0);
    // All sixteen MLU planes with carry in as plane bit 3
    for (int i = 0; i < 16; i++) begin
      ucode[6'(OPC_MLU_BASE + i)] = make_word(IN_NONE, OUT_MLU, 4'(i), OP_REG0, 5'd0);
    end
  endtask

  // Result in bits 7..0 and carry out in bit 8
  function automatic logic [8:0] mlu_model(input logic [7:0] a, input logic [7:0] b,
                                           input logic [3:0] plane);
    int ai;
    int bi;
    int ci;
    int r;
    ai = int'(a);
    bi = int'(b);
    ci = int'(plane[3]);
    case (mlu_op_e'(plane[2:0]))
      MLU_AND:    return {1'b0, a & b};
      MLU_OR:     return {1'b0, a | b};
      MLU_XOR:    return {1'b0, a ^ b};
      MLU_ADD: begin
        r = ai + bi + ci;
        return {r > 255, r[7:0]};
      end
      MLU_SUB: begin
        // Carry in high means no borrow pending
        r = ai - bi - (1 - ci);
        return {r >= 0, r[7:0]};
      end
      MLU_NOT_A:  return {1'b0, ~a};
      MLU_PASS_A: return {1'b0, a};
      default:    return {1'b0, b};
    endcase
  endfunction

  function automatic logic [7:0] shift_model(input logic [7:0] a, input logic [1:0] mode);
    case (mode)
      2'b01:   return a >> 1;
      2'b11:   return (a >> 1) | (a & 8'h80);
      default: return 8'(a << 1);
    endcase
  endfunction

  task automatic model_exec(input logic [5:0] op, input logic [7:0] ext,
                            output logic [7:0] exp_bus);
    ctrl_word_t w;
    logic [1:0] idx;
    logic [8:0] alu_out;
    w = ucode[op];
    case (w.reg_sel)
      OP_REG0: idx = op[1:0];
      OP_REG1: idx = op[3:2];
      default: idx = w.reg_src[1:0];
    endcase
    alu_out = mlu_model(m_tmp0, m_tmp1, w.alu_plane);
    case (w.out_plane)
      OUT_REG:     exp_bus = m_regs[idx];
      OUT_TMP0:    exp_bus = m_tmp0;
      OUT_TMP1:    exp_bus = m_tmp1;
      OUT_MLU:     exp_bus = alu_out[7:0];
      OUT_SHIFTER: exp_bus = shift_model(m_tmp0, w.alu_plane[1:0]);
      OUT_EXT:     exp_bus = ext;
      default:     exp_bus = 8'h00;
    endcase
    case (w.in_plane)
      IN_REG:  m_regs[idx] = exp_bus;
      IN_TMP0: m_tmp0 = exp_bus;
      IN_TMP1: m_tmp1 = exp_bus;
      default: ;
    endcase
    if (w.out_plane == OUT_MLU) begin
      m_carry = alu_out[8];
    end
  endtask

  // Issue a new op and check the op now in exec at mid-cycle
  task automatic step(input logic v, input logic [5:0] op, input logic [7:0] ext);
    logic [7:0] exp_bus;
    @(posedge clk);
    #1;
    op_valid = v;
    opcode   = op;
    ext_data = pend_ext;
    #4;
    check_eq("done", 8'(done), 8'(pend_valid));
    check_eq("carry", 8'(carry), 8'(m_carry));
    if (pend_valid) begin
      model_exec(pend_op, pend_ext, exp_bus);
      check_eq("bus", bus, exp_bus);
    end else begin
      check_eq("bus", bus, 8'h00);
    end
    pend_valid = v && booted;
    pend_op    = op;
    pend_ext   = ext;
  endtask

  task automatic run_op(input logic [5:0] op, input logic [7:0] ext);
    step(1'b1, op, ext);
    step(1'b0, 6'h00, 8'h00);
  endtask

  // Four byte writes per word with lane 3 as the top byte
  task automatic boot_table();
    for (int op = 0; op < 64; op++) begin
      for (int lane = 0; lane < 4; lane++) begin
        @(posedge clk);
        #1;
        boot_we   = 1'b1;
        boot_addr = {4'b0000, 6'(op), 2'(lane)};
        boot_data = ucode[6'(op)][lane * 8 +: 8];
      end
    end
    @(posedge clk);
    #1;
    boot_we   = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    @(posedge clk);
    #1;
    booted = 1'b1;
  endtask

  task automatic gating_before_boot();
    step(1'b1, OPC_EXT_TMP0, rand_byte());
    step(1'b0, 6'h00, 8'h00);
    step(1'b1, OPC_EXT_TMP1, rand_byte());
    step(1'b1, OPC_EXT_TMP0, rand_byte());
    step(1'b1, OPC_RD_TMP0, 8'h00);
    step(1'b0, 6'h00, 8'h00);
    boot_table();
    // Ignored ops left tmp0 at zero
    run_op(OPC_RD_TMP0, 8'h00);
    run_op(OPC_EXT_TMP0, rand_byte());
    run_op(OPC_RD_TMP0, 8'h00);
  endtask

  task automatic reg_select_modes();
    for (int m = 0; m < 3; m++) begin
      for (int r = 0; r < 4; r++) begin
        case (m)
          0:       run_op(6'(r), rand_byte());
          1:       run_op(6'(16 + 4 * r), rand_byte());
          default: run_op(6'(32 + r), rand_byte());
        endcase
      end
      for (int r = 0; r < 4; r++) begin
        case (m)
          0:       run_op(6'(4 + r), 8'h00);
          1:       run_op(6'(17 + 4 * r), 8'h00);
          default: run_op(6'(36 + r), 8'h00);
        endcase
      end
    end
  endtask

  task automatic mlu_all_ops();
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 16; i++) begin
        run_op(OPC_EXT_TMP0, rand_byte());
        run_op(OPC_EXT_TMP1, rand_byte());
        run_op(6'(OPC_MLU_BASE + i), 8'h00);
      end
    end
  endtask

  task automatic shifter_modes();
    logic [7:0] v;
    for (int k = 0; k < 4; k++) begin
      v = rand_byte();
      // Odd rounds carry a sign bit
      v[7] = (k % 2 == 1);
      run_op(OPC_EXT_TMP0, v);
      run_op(OPC_SHL, 8'h00);
      run_op(OPC_SHR, 8'h00);
      run_op(OPC_SAR, 8'h00);
    end
  endtask

  task automatic back_to_back_ops();
    step(1'b1, OPC_EXT_TMP0, rand_byte());
    step(1'b1, OPC_EXT_TMP1, rand_byte());
    step(1'b1, OPC_ADD_TMP0, 8'h00);
    step(1'b1, OPC_RD_TMP0, 8'h00);
    step(1'b1, OPC_SHL_TMP1, 8'h00);
    step(1'b1, OPC_RD_TMP1, 8'h00);
    step(1'b1, OPC_TMP0_REG2, 8'h00);
    step(1'b1, OPC_RD_REG2, 8'h00);
    // Live external operand that must stay off the bus
    step(1'b1, OPC_NOP, rand_byte());
    step(1'b0, 6'h00, 8'h00);
    step(1'b0, 6'h00, 8'h00);
  endtask

  initial begin
    arst_n     = 1'b0;
    op_valid   = 1'b0;
    opcode     = '0;
    booted     = 1'b0;
    boot_we    = 1'b0;
    boot_addr  = '0;
    boot_data  = '0;
    ext_data   = '0;
    pend_valid = 1'b0;
    pend_op    = '0;
    pend_ext   = '0;
    m_tmp0     = '0;
    m_tmp1     = '0;
    m_carry    = 1'b0;
    lfsr_state = 32'h6ef99288;
    for (int r = 0; r < `REG_COUNT; r++) begin
      m_regs[2'(r)] = '0;
    end
    build_table();
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    #4;
    check_eq("done", 8'(done), 8'h00);
    check_eq("bus", bus, 8'h00);
    check_eq("carry", 8'(carry), 8'h00);
    gating_before_boot();
    reg_select_modes();
    mlu_all_ops();
    shifter_modes();
    back_to_back_ops();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`include "cpu_params.svh"

`default_nettype none

module cpu_core (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    op_valid,
  input  logic [`OPCODE_W-1:0]    opcode,
  input  logic                    booted,
  input  logic                    boot_we,
  input  logic [`BOOT_ADDR_W-1:0] boot_addr,
  input  logic [`DATA_W-1:0]      boot_data,
  input  logic [`DATA_W-1:0]      ext_data,
  output logic                    done,
  output logic [`DATA_W-1:0]      bus,
  output logic                    carry
);

  import alu_pkg::*;

  logic               exec;
  logic [3:0]         alu_plane;
  logic [1:0]         reg_index;
  logic               reg_n_in;
  logic               tmp0_n_in;
  logic               tmp1_n_in;
  logic               reg_n_out;
  logic               tmp0_n_out;
  logic               tmp1_n_out;
  logic               mlu_n_out;
  logic               shifter_n_out;
  logic               ext_n_out;
  logic [`DATA_W-1:0] tmp0;
  logic [`DATA_W-1:0] tmp1;
  logic [`DATA_W-1:0] mlu_result;
  logic               mlu_carry;
  logic [`DATA_W-1:0] shifter_result;

  // Op completes in its exec cycle
  assign done = exec;

  control_logic u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .op_valid      (op_valid),
    .opcode        (opcode),
    .booted        (booted),
    .boot_we       (boot_we),
    .boot_addr     (boot_addr),
    .boot_data     (boot_data),
    .exec          (exec),
    .alu_plane     (alu_plane),
    .reg_index     (reg_index),
    .reg_n_in      (reg_n_in),
    .tmp0_n_in     (tmp0_n_in),
    .tmp1_n_in     (tmp1_n_in),
    .reg_n_out     (reg_n_out),
    .tmp0_n_out    (tmp0_n_out),
    .tmp1_n_out    (tmp1_n_out),
    .mlu_n_out     (mlu_n_out),
    .shifter_n_out (shifter_n_out),
    .ext_n_out     (ext_n_out)
  );

  // Both units see the same ALU plane, the out plane picks one
  mlu u_mlu (
    .a         (tmp0),
    .b         (tmp1),
    .op        (mlu_op_e'(alu_plane[2:0])),
    .carry_in  (alu_plane[CARRY_BIT]),
    .result    (mlu_result),
    .carry_out (mlu_carry)
  );

  shifter u_shifter (
    .a      (tmp0),
    .mode   (shift_mode_t'(alu_plane[1:0])),
    .result (shifter_result)
  );

  register_bus u_regs (
    .clk            (clk),
    .arst_n         (arst_n),
    .ext_data       (ext_data),
    .reg_index      (reg_index),
    .reg_n_in       (reg_n_in),
    .tmp0_n_in      (tmp0_n_in),
    .tmp1_n_in      (tmp1_n_in),
    .reg_n_out      (reg_n_out),
    .tmp0_n_out     (tmp0_n_out),
    .tmp1_n_out     (tmp1_n_out),
    .mlu_n_out      (mlu_n_out),
    .shifter_n_out  (shifter_n_out),
    .ext_n_out      (ext_n_out),
    .mlu_result     (mlu_result),
    .mlu_carry      (mlu_carry),
    .shifter_result (shifter_result),
    .bus            (bus),
    .tmp0           (tmp0),
    .tmp1           (tmp1),
    .carry          (carry)
  );

endmodule

`default_nettype wire

/* rtl/register_bus.sv */
`include "cpu_params.svh"

`default_nettype none

module register_bus (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [`DATA_W-1:0] ext_data,
  input  logic [1:0]         reg_index,
  input  logic               reg_n_in,
  input  logic               tmp0_n_in,
  input  logic               tmp1_n_in,
  input  logic               reg_n_out,
  input  logic               tmp0_n_out,
  input  logic               tmp1_n_out,
  input  logic               mlu_n_out,
  input  logic               shifter_n_out,
  input  logic               ext_n_out,
  input  logic [`DATA_W-1:0] mlu_result,
  input  logic               mlu_carry,
  input  logic [`DATA_W-1:0] shifter_result,
  output logic [`DATA_W-1:0] bus,
  output logic [`DATA_W-1:0] tmp0,
  output logic [`DATA_W-1:0] tmp1,
  output logic               carry
);

  // General register file
  logic [`DATA_W-1:0] regs [`REG_COUNT];

  // Wired-OR of gated sources, bus reads zero when nothing drives it
  assign bus = ({`DATA_W{!reg_n_out}}     & regs[reg_index])
             | ({`DATA_W{!tmp0_n_out}}    & tmp0)
             | ({`DATA_W{!tmp1_n_out}}    & tmp1)
             | ({`DATA_W{!mlu_n_out}}     & mlu_result)
             | ({`DATA_W{!shifter_n_out}} & shifter_result)
             | ({`DATA_W{!ext_n_out}}     & ext_data);

  // Destination latches at the edge that ends exec
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      tmp0  <= '0;
      tmp1  <= '0;
      carry <= 1'b0;
    end else begin
      if (!reg_n_in) begin
        regs[reg_index] <= bus;
      end
      if (!tmp0_n_in) begin
        tmp0 <= bus;
      end
      if (!tmp1_n_in) begin
        tmp1 <= bus;
      end
      // Carry only follows MLU results
      if (!mlu_n_out) begin
        carry <= mlu_carry;
      end
    end
  end

  // Out plane decoder never enables two drivers
  a_one_driver: assert property (
    @(posedge clk) disable iff (!arst_n)
    $countones(~{reg_n_out, tmp0_n_out, tmp1_n_out,
                 mlu_n_out, shifter_n_out, ext_n_out}) <= 1
  ) else $error("bus contention");

endmodule

`default_nettype wire

/* rtl/shifter.sv */
`include "cpu_params.svh"

`default_nettype none

module shifter (
  input  logic [`DATA_W-1:0]  a,
  input  alu_pkg::shift_mode_t mode,
  output logic [`DATA_W-1:0]  result
);

  import alu_pkg::*;

  // One place only, like a pair of 74-series shift muxes
  always_comb begin
    case (mode)
      SHIFT_LEFT: begin
        result = {a[`DATA_W-2:0], 1'b0};
      end
      SHIFT_RIGHT_LOGIC: begin
        result = {1'b0, a[`DATA_W-1:1]};
      end
      SHIFT_RIGHT_ARITH: begin
        // Sign bit is kept
        result = {a[`DATA_W-1], a[`DATA_W-1:1]};
      end
      default: begin
        // Left arithmetic is illegal, behaves as a plain left shift
        result = {a[`DATA_W-2:0], 1'b0};
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/mlu.sv */
`include "cpu_params.svh"

`default_nettype none

module mlu (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  alu_pkg::mlu_op_e   op,
  input  logic               carry_in,
  output logic [`DATA_W-1:0] result,
  output logic               carry_out
);

  import alu_pkg::*;

  // Shared adder, b inverted for subtract
  logic [`DATA_W:0]   sum;
  logic [`DATA_W-1:0] addend;

  assign addend = (op == MLU_SUB) ? ~b : b;

  // For SUB, a + ~b + c is a - b - !c and the top bit means no borrow
  assign sum = {1'b0, a} + {1'b0, addend} + {{`DATA_W{1'b0}}, carry_in};

  always_comb begin
    // Logic functions leave carry clear
    carry_out = 1'b0;
    case (op)
      MLU_AND:    result = a & b;
      MLU_OR:     result = a | b;
      MLU_XOR:    result = a ^ b;
      MLU_ADD,
      MLU_SUB: begin
        result    = sum[`DATA_W-1:0];
        carry_out = sum[`DATA_W];
      end
      MLU_NOT_A:  result = ~a;
      MLU_PASS_A: result = a;
      MLU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/control_logic.sv */
`include "cpu_params.svh"

`default_nettype none

module control_logic (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    op_valid,
  input  logic [`OPCODE_W-1:0]    opcode,
  input  logic                    booted,
  input  logic                    boot_we,
  input  logic [`BOOT_ADDR_W-1:0] boot_addr,
  input  logic [`DATA_W-1:0]      boot_data,
  output logic                    exec,
  output logic [3:0]              alu_plane,
  output logic [1:0]              reg_index,
  output logic                    reg_n_in,
  output logic                    tmp0_n_in,
  output logic                    tmp1_n_in,
  output logic                    reg_n_out,
  output logic                    tmp0_n_out,
  output logic                    tmp1_n_out,
  output logic                    mlu_n_out,
  output logic                    shifter_n_out,
  output logic                    ext_n_out
);

  import ctrl_pkg::*;
  import alu_pkg::*;

  ctrl_word_t           ctrl_word;
  logic                 op_fire;
  logic [`OPCODE_W-1:0] opcode_q;

  // Ops before boot are dropped
  assign op_fire = op_valid && booted;

  microcode_store u_store (
    .clk       (clk),
    .boot_we   (boot_we),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .rd_en     (op_fire),
    .rd_addr   (opcode),
    .rd_data   (ctrl_word)
  );

  // exec lines up with the registered control word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exec     <= 1'b0;
      opcode_q <= '0;
    end else begin
      exec <= op_fire;
      if (op_fire) begin
        opcode_q <= opcode;
      end
    end
  end

  assign alu_plane = ctrl_word.alu_plane;

  // In plane decoder, active low
  assign reg_n_in  = !(exec && ctrl_word.in_plane == IN_REG);
  assign tmp0_n_in = !(exec && ctrl_word.in_plane == IN_TMP0);
  assign tmp1_n_in = !(exec && ctrl_word.in_plane == IN_TMP1);

  // Out plane decoder, active low
  assign reg_n_out     = !(exec && ctrl_word.out_plane == OUT_REG);
  assign tmp0_n_out    = !(exec && ctrl_word.out_plane == OUT_TMP0);
  assign tmp1_n_out    = !(exec && ctrl_word.out_plane == OUT_TMP1);
  assign mlu_n_out     = !(exec && ctrl_word.out_plane == OUT_MLU);
  assign shifter_n_out = !(exec && ctrl_word.out_plane == OUT_SHIFTER);
  assign ext_n_out     = !(exec && ctrl_word.out_plane == OUT_EXT);

  // Register index from the opcode or from the microcode
  always_comb begin
    case (ctrl_word.reg_sel)
      OP_REG0:  reg_index = opcode_q[1:0];
      OP_REG1:  reg_index = opcode_q[3:2];
      CTRL_SRC: reg_index = ctrl_word.reg_src[1:0];
      default:  reg_index = 2'd0;
    endcase
  end

  // Microcode must name a real register selector
  a_reg_sel_valid: assert property (
    @(posedge clk) disable iff (!arst_n) exec |-> ctrl_word.reg_sel != REG_SEL_INVALID
  ) else $error("invalid reg_sel during exec");

  // A unit never drives the bus and loads from it in the same op
  a_no_self_loop: assert property (
    @(posedge clk) disable iff (!arst_n)
    (reg_n_in || reg_n_out) && (tmp0_n_in || tmp0_n_out) && (tmp1_n_in || tmp1_n_out)
  ) else $error("unit is both source and destination");

  // Left arithmetic shift has no meaning
  a_no_left_arith: assert property (
    @(posedge clk) disable iff (!arst_n)
    !shifter_n_out |-> shift_mode_t'(alu_plane[1:0]) != SHIFT_LEFT_ARITH
  ) else $error("left arithmetic shift selected");

  // Microcode is frozen once booted
  a_no_boot_write: assert property (
    @(posedge clk) disable iff (!arst_n) booted |-> !boot_we
  ) else $error("bootstrap write after boot");

endmodule

`default_nettype wire

/* rtl/microcode_store.sv */
`include "cpu_params.svh"

`default_nettype none

module microcode_store (
  input  logic                      clk,
  input  logic                      boot_we,
  input  logic [`BOOT_ADDR_W-1:0]   boot_addr,
  input  logic [`DATA_W-1:0]        boot_data,
  input  logic                      rd_en,
  input  logic [`OPCODE_W-1:0]      rd_addr,
  output ctrl_pkg::ctrl_word_t      rd_data
);

  import ctrl_pkg::*;

  // One control word per opcode
  logic [`UCODE_W-1:0] mem [2**`OPCODE_W];

  // Bootstrap address split
  logic [`OPCODE_W-1:0] boot_op;
  logic [1:0]           boot_lane;

  assign boot_op   = boot_addr[`OPCODE_W+1:2];
  assign boot_lane = boot_addr[1:0];

  // Byte wide load, lane 3 is the top byte
  always_ff @(posedge clk) begin
    if (boot_we) begin
      mem[boot_op][boot_lane*`DATA_W +: `DATA_W] <= boot_data;
    end
  end

  // Registered read, word valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= ctrl_word_t'(mem[rd_addr]);
    end
  end

  // Bootstrap only reaches the first 64 words
  a_boot_addr_range: assert property (
    @(posedge clk) boot_we |-> (boot_addr[`BOOT_ADDR_W-1:`OPCODE_W+2] == '0)
  ) else $error("bootstrap write above microcode range");

  // Loading and executing never overlap
  a_no_rw_overlap: assert property (
    @(posedge clk) !(boot_we && rd_en)
  ) else $error("microcode read during bootstrap write");

endmodule

`default_nettype wire

/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // MLU function, low three bits of the ALU plane
  typedef enum logic [2:0] {
    MLU_AND    = 3'd0,
    MLU_OR     = 3'd1,
    MLU_XOR    = 3'd2,
    MLU_ADD    = 3'd3,
    MLU_SUB    = 3'd4,
    MLU_NOT_A  = 3'd5,
    MLU_PASS_A = 3'd6,
    MLU_PASS_B = 3'd7
  } mlu_op_e;

  // Carry in sits above the op field
  localparam int CARRY_BIT = 3;

  // Shifter mode, low two bits of the ALU plane
  typedef struct packed {
    logic arith;
    logic right;
  } shift_mode_t;

  localparam shift_mode_t SHIFT_LEFT        = '{arith: 1'b0, right: 1'b0};
  localparam shift_mode_t SHIFT_RIGHT_LOGIC = '{arith: 1'b0, right: 1'b1};
  localparam shift_mode_t SHIFT_LEFT_ARITH  = '{arith: 1'b1, right: 1'b0};
  localparam shift_mode_t SHIFT_RIGHT_ARITH = '{arith: 1'b1, right: 1'b1};

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  // Destination selector, decoded into active-low in strobes
  typedef enum logic [2:0] {
    IN_NONE = 3'd0,
    IN_REG  = 3'd1,
    IN_TMP0 = 3'd2,
    IN_TMP1 = 3'd3
  } in_plane_e;

  // Bus source selector, decoded into active-low out strobes
  typedef enum logic [2:0] {
    OUT_NONE    = 3'd0,
    OUT_REG     = 3'd1,
    OUT_TMP0    = 3'd2,
    OUT_TMP1    = 3'd3,
    OUT_MLU     = 3'd4,
    OUT_SHIFTER = 3'd5,
    OUT_EXT     = 3'd6
  } out_plane_e;

  // Where the register index comes from
  typedef enum logic [1:0] {
    OP_REG0         = 2'd0,
    OP_REG1         = 2'd1,
    CTRL_SRC        = 2'd2,
    REG_SEL_INVALID = 2'd3
  } reg_sel_e;

  // Microcode word, MSB first
  typedef struct packed {
    in_plane_e   in_plane;
    out_plane_e  out_plane;
    logic [3:0]  alu_plane;
    reg_sel_e    reg_sel;
    logic [4:0]  reg_src;
    logic [14:0] unused;
  } ctrl_word_t;

endpackage

`default_nettype wire

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus and register width
`define DATA_W 8

// Opcode width, one microcode word per opcode
`define OPCODE_W 6

// General purpose registers behind the register plane
`define REG_COUNT 4

// Microcode control word width
`define UCODE_W 32

// Bootstrap address, opcode in 7..2 and byte lane in 1..0
`define BOOT_ADDR_W 12

`endif
